// ==== hw/debayer_pkg.sv ====
`default_nettype none

package debayer_pkg;

	// colour position of the window centre in a BGGR mosaic
	// high bit is row parity, low bit is column parity
	typedef enum logic [1:0]
	{
		SITE_B          = 2'b00,	// even row, even column
		SITE_G_BLUE_ROW = 2'b01,	// even row, odd column
		SITE_G_RED_ROW  = 2'b10,	// odd row, even column
		SITE_R          = 2'b11	// odd row, odd column
	} bayer_site_e;

	// headroom so a sum of four samples never wraps
	localparam int SUM_GUARD_BITS = 2;

endpackage

`default_nettype wire

// ==== hw/line_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_ram
#(
	parameter int PIXEL_WIDTH = 10,
	parameter int IMG_WIDTH   = 640,
	localparam int ADDR_WIDTH = $clog2(IMG_WIDTH)
)
(
	input  wire                   clk_i,
	input  wire                   en_i,
	input  wire [ADDR_WIDTH-1:0]  addr_i,
	input  wire [PIXEL_WIDTH-1:0] wr_data_i,
	output logic [PIXEL_WIDTH-1:0] rd_data_o
);

	logic [PIXEL_WIDTH-1:0] mem [0:IMG_WIDTH-1];	// one line of samples

	// read-before-write, so rd_data_o gets what was stored one pass earlier
	always_ff @(posedge clk_i)
	begin
		if (en_i)
		begin
			rd_data_o    <= mem[addr_i];
			mem[addr_i] <= wr_data_i;
		end
	end

endmodule

`default_nettype wire

// ==== hw/column_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module column_fetch
	import debayer_pkg::*;
#(
	parameter int PIXEL_WIDTH = 10,
	parameter int IMG_WIDTH   = 640
)
(
	input  wire                    clk_i,
	input  wire                    line_valid_i,
	input  wire                    pipe_advance_i,
	input  wire                    pix_valid_i,
	input  wire [PIXEL_WIDTH-1:0]  pix_data_i,
	input  wire                    pix_sof_i,
	output logic                   col_valid_o,
	output logic [PIXEL_WIDTH-1:0] col_top_o,
	output logic [PIXEL_WIDTH-1:0] col_mid_o,
	output logic [PIXEL_WIDTH-1:0] col_bot_o,
	output bayer_site_e            col_site_o,
	output logic                   col_emit_o
);

	localparam int ADDR_WIDTH = $clog2(IMG_WIDTH);
	localparam int ROW_WIDTH  = 16;

	logic                   accept;
	logic [ADDR_WIDTH-1:0]  col_q;
	logic [ADDR_WIDTH-1:0]  col_cur;
	logic [ADDR_WIDTH-1:0]  col_next;
	logic [ADDR_WIDTH-1:0]  dly_q;	// lb_prev2 ring pointer
	logic [ADDR_WIDTH-1:0]  dly_cur;
	logic [ADDR_WIDTH-1:0]  dly_next;
	logic [ROW_WIDTH-1:0]   row_q;
	logic [ROW_WIDTH-1:0]   row_cur;
	logic [ROW_WIDTH-1:0]   row_next;
	logic                   emit_cur;
	bayer_site_e            site_cur;
	logic [PIXEL_WIDTH-1:0] prev_rd;
	logic [PIXEL_WIDTH-1:0] prev2_rd;

	assign accept = pipe_advance_i & pix_valid_i;

	always_comb
	begin
		col_cur = pix_sof_i ? '0 : col_q;	// sof pins the pixel to row 0, column 0
		row_cur = pix_sof_i ? '0 : row_q;
		dly_cur = pix_sof_i ? '0 : dly_q;
		col_next = (col_cur == ADDR_WIDTH'(IMG_WIDTH - 1)) ? '0 : col_cur + 1'b1;
		row_next = (col_cur == ADDR_WIDTH'(IMG_WIDTH - 1)) ? row_cur + 1'b1 : row_cur;
		dly_next = (dly_cur == ADDR_WIDTH'(IMG_WIDTH - 2)) ? '0 : dly_cur + 1'b1;
		// centre sits one row up and one column left of the incoming pixel
		site_cur = bayer_site_e'({~row_cur[0], ~col_cur[0]});
		emit_cur = (row_cur >= ROW_WIDTH'(2)) && (col_cur >= ADDR_WIDTH'(2));
	end

	always_ff @(posedge clk_i or posedge line_valid_i)
	begin
		if (line_valid_i)
		begin
			col_q <= '0;
			row_q <= '0;
			dly_q <= '0;
		end
		else if (accept)
		begin
			col_q <= col_next;
			row_q <= row_next;
			dly_q <= dly_next;
		end
	end

	always_ff @(posedge clk_i or posedge line_valid_i)
	begin
		if (line_valid_i)
		begin
			col_valid_o <= 1'b0;
			col_emit_o  <= 1'b0;
		end
		else if (pipe_advance_i)
		begin
			col_valid_o <= pix_valid_i;	// an empty beat travels on as a bubble
			col_emit_o  <= pix_valid_i & emit_cur;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (accept)
		begin
			col_bot_o  <= pix_data_i;	// lines up with the registered memory reads
			col_site_o <= site_cur;
		end
	end

	// row y-1, written with the incoming pixel
	line_ram #(.PIXEL_WIDTH(PIXEL_WIDTH), .IMG_WIDTH(IMG_WIDTH)) lb_prev
	(
		.clk_i     (clk_i),
		.en_i      (accept),
		.addr_i    (col_cur),
		.wr_data_i (pix_data_i),
		.rd_data_o (prev_rd)
	);

	// Row y-2. The lb_prev word arrives one pixel late, so this memory runs as a
	// ring of IMG_WIDTH-1 entries to keep the total delay at exactly one line.
	line_ram #(.PIXEL_WIDTH(PIXEL_WIDTH), .IMG_WIDTH(IMG_WIDTH)) lb_prev2
	(
		.clk_i     (clk_i),
		.en_i      (accept),
		.addr_i    (dly_cur),
		.wr_data_i (prev_rd),
		.rd_data_o (prev2_rd)
	);

	assign col_top_o = prev2_rd;
	assign col_mid_o = prev_rd;

endmodule

`default_nettype wire

// ==== hw/window_3x3.sv ====
`timescale 1ns/1ps
`default_nettype none

module window_3x3
	import debayer_pkg::*;
#(
	parameter int PIXEL_WIDTH = 10
)
(
	input  wire                    clk_i,
	input  wire                    line_valid_i,
	input  wire                    pipe_advance_i,
	input  wire                    col_valid_i,
	input  wire [PIXEL_WIDTH-1:0]  col_top_i,
	input  wire [PIXEL_WIDTH-1:0]  col_mid_i,
	input  wire [PIXEL_WIDTH-1:0]  col_bot_i,
	input  var bayer_site_e        col_site_i,
	input  wire                    col_emit_i,
	output logic                   win_valid_o,
	output logic [PIXEL_WIDTH-1:0] win_tl_o,
	output logic [PIXEL_WIDTH-1:0] win_tc_o,
	output logic [PIXEL_WIDTH-1:0] win_tr_o,
	output logic [PIXEL_WIDTH-1:0] win_ml_o,
	output logic [PIXEL_WIDTH-1:0] win_mc_o,
	output logic [PIXEL_WIDTH-1:0] win_mr_o,
	output logic [PIXEL_WIDTH-1:0] win_bl_o,
	output logic [PIXEL_WIDTH-1:0] win_bc_o,
	output logic [PIXEL_WIDTH-1:0] win_br_o,
	output bayer_site_e            win_site_o,
	output logic                   win_emit_o
);

	logic shift_en;

	assign shift_en = pipe_advance_i & col_valid_i;	// bubbles leave the window untouched

	always_ff @(posedge clk_i or posedge line_valid_i)
	begin
		if (line_valid_i)
		begin
			win_valid_o <= 1'b0;
			win_emit_o  <= 1'b0;
		end
		else if (pipe_advance_i)
		begin
			win_valid_o <= col_valid_i;
			win_emit_o  <= col_valid_i & col_emit_i;
		end
	end

	// oldest column on the left, newest on the right
	always_ff @(posedge clk_i)
	begin
		if (shift_en)
		begin
			win_tl_o   <= win_tc_o;
			win_tc_o   <= win_tr_o;
			win_tr_o   <= col_top_i;
			win_ml_o   <= win_mc_o;
			win_mc_o   <= win_mr_o;
			win_mr_o   <= col_mid_i;
			win_bl_o   <= win_bc_o;
			win_bc_o   <= win_br_o;
			win_br_o   <= col_bot_i;
			win_site_o <= col_site_i;	// site already refers to the middle column
		end
	end

endmodule

`default_nettype wire

// ==== hw/bilinear_interp.sv ====
`timescale 1ns/1ps
`default_nettype none

module bilinear_interp
	import debayer_pkg::*;
#(
	parameter int PIXEL_WIDTH = 10
)
(
	input  wire                    clk_i,
	input  wire                    line_valid_i,
	input  wire                    win_valid_i,
	input  wire [PIXEL_WIDTH-1:0]  win_tl_i,
	input  wire [PIXEL_WIDTH-1:0]  win_tc_i,
	input  wire [PIXEL_WIDTH-1:0]  win_tr_i,
	input  wire [PIXEL_WIDTH-1:0]  win_ml_i,
	input  wire [PIXEL_WIDTH-1:0]  win_mc_i,
	input  wire [PIXEL_WIDTH-1:0]  win_mr_i,
	input  wire [PIXEL_WIDTH-1:0]  win_bl_i,
	input  wire [PIXEL_WIDTH-1:0]  win_bc_i,
	input  wire [PIXEL_WIDTH-1:0]  win_br_i,
	input  var bayer_site_e        win_site_i,
	input  wire                    win_emit_i,
	output logic                   pipe_advance_o,
	output logic                   rgb_valid_o,
	input  wire                    rgb_ready_i,
	output logic [PIXEL_WIDTH-1:0] rgb_red_o,
	output logic [PIXEL_WIDTH-1:0] rgb_green_o,
	output logic [PIXEL_WIDTH-1:0] rgb_blue_o
);

	localparam int QUAD_WIDTH = PIXEL_WIDTH + SUM_GUARD_BITS;
	localparam int PAIR_WIDTH = PIXEL_WIDTH + 1;

	logic [QUAD_WIDTH-1:0]  orth_sum;
	logic [QUAD_WIDTH-1:0]  diag_sum;
	logic [PAIR_WIDTH-1:0]  horz_sum;
	logic [PAIR_WIDTH-1:0]  vert_sum;
	logic [PIXEL_WIDTH-1:0] orth_avg;
	logic [PIXEL_WIDTH-1:0] diag_avg;
	logic [PIXEL_WIDTH-1:0] horz_avg;
	logic [PIXEL_WIDTH-1:0] vert_avg;
	logic [PIXEL_WIDTH-1:0] red_d;
	logic [PIXEL_WIDTH-1:0] green_d;
	logic [PIXEL_WIDTH-1:0] blue_d;
	logic                   load;

	assign orth_sum = QUAD_WIDTH'(win_tc_i) + QUAD_WIDTH'(win_bc_i)
		+ QUAD_WIDTH'(win_ml_i) + QUAD_WIDTH'(win_mr_i);
	assign diag_sum = QUAD_WIDTH'(win_tl_i) + QUAD_WIDTH'(win_tr_i)
		+ QUAD_WIDTH'(win_bl_i) + QUAD_WIDTH'(win_br_i);
	assign horz_sum = PAIR_WIDTH'(win_ml_i) + PAIR_WIDTH'(win_mr_i);
	assign vert_sum = PAIR_WIDTH'(win_tc_i) + PAIR_WIDTH'(win_bc_i);

	// dropping the low bits is the truncating shift
	assign orth_avg = orth_sum[QUAD_WIDTH-1:SUM_GUARD_BITS];
	assign diag_avg = diag_sum[QUAD_WIDTH-1:SUM_GUARD_BITS];
	assign horz_avg = horz_sum[PAIR_WIDTH-1:1];
	assign vert_avg = vert_sum[PAIR_WIDTH-1:1];

	always_comb
	begin
		red_d   = win_mc_i;
		green_d = win_mc_i;
		blue_d  = win_mc_i;
		case (win_site_i)
			SITE_B:
			begin
				red_d   = diag_avg;
				green_d = orth_avg;
			end
			SITE_G_BLUE_ROW:
			begin
				red_d  = vert_avg;	// red rows lie above and below
				blue_d = horz_avg;
			end
			SITE_G_RED_ROW:
			begin
				red_d  = horz_avg;
				blue_d = vert_avg;
			end
			SITE_R:
			begin
				green_d = orth_avg;
				blue_d  = diag_avg;
			end
		endcase
	end

	assign pipe_advance_o = ~rgb_valid_o | rgb_ready_i;	// empty or draining this cycle
	assign load           = pipe_advance_o & win_valid_i & win_emit_i;

	always_ff @(posedge clk_i or posedge line_valid_i)
	begin
		if (line_valid_i)
			rgb_valid_o <= 1'b0;
		else if (pipe_advance_o)
			rgb_valid_o <= win_valid_i & win_emit_i;
	end

	always_ff @(posedge clk_i)
	begin
		if (load)
		begin
			rgb_red_o   <= red_d;
			rgb_green_o <= green_d;
			rgb_blue_o  <= blue_d;
		end
	end

endmodule

`default_nettype wire

// ==== hw/debayer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module debayer_top
	import debayer_pkg::*;
#(
	parameter int PIXEL_WIDTH = 10,
	parameter int IMG_WIDTH   = 640
)
(
	input  wire                    clk_i,
	input  wire                    line_valid_i,
	input  wire                    pix_valid_i,
	output logic                   pix_ready_o,
	input  wire [PIXEL_WIDTH-1:0]  pix_data_i,
	input  wire                    pix_sof_i,
	output logic                   rgb_valid_o,
	input  wire                    rgb_ready_i,
	output logic [PIXEL_WIDTH-1:0] rgb_red_o,
	output logic [PIXEL_WIDTH-1:0] rgb_green_o,
	output logic [PIXEL_WIDTH-1:0] rgb_blue_o
);

	logic                   pipe_advance;	// one enable for every stage
	logic                   col_valid;
	logic [PIXEL_WIDTH-1:0] col_top;
	logic [PIXEL_WIDTH-1:0] col_mid;
	logic [PIXEL_WIDTH-1:0] col_bot;
	bayer_site_e            col_site;
	logic                   col_emit;
	logic                   win_valid;
	logic [PIXEL_WIDTH-1:0] win_tl;
	logic [PIXEL_WIDTH-1:0] win_tc;
	logic [PIXEL_WIDTH-1:0] win_tr;
	logic [PIXEL_WIDTH-1:0] win_ml;
	logic [PIXEL_WIDTH-1:0] win_mc;
	logic [PIXEL_WIDTH-1:0] win_mr;
	logic [PIXEL_WIDTH-1:0] win_bl;
	logic [PIXEL_WIDTH-1:0] win_bc;
	logic [PIXEL_WIDTH-1:0] win_br;
	bayer_site_e            win_site;
	logic                   win_emit;

	assign pix_ready_o = pipe_advance;

	column_fetch #(.PIXEL_WIDTH(PIXEL_WIDTH), .IMG_WIDTH(IMG_WIDTH)) u_column_fetch
	(
		.clk_i(clk_i), .line_valid_i(line_valid_i), .pipe_advance_i(pipe_advance),
		.pix_valid_i(pix_valid_i), .pix_data_i(pix_data_i), .pix_sof_i(pix_sof_i),
		.col_valid_o(col_valid), .col_top_o(col_top), .col_mid_o(col_mid),
		.col_bot_o(col_bot), .col_site_o(col_site), .col_emit_o(col_emit)
	);

	window_3x3 #(.PIXEL_WIDTH(PIXEL_WIDTH)) u_window_3x3
	(
		.clk_i(clk_i), .line_valid_i(line_valid_i), .pipe_advance_i(pipe_advance),
		.col_valid_i(col_valid), .col_top_i(col_top), .col_mid_i(col_mid),
		.col_bot_i(col_bot), .col_site_i(col_site), .col_emit_i(col_emit),
		.win_valid_o(win_valid),
		.win_tl_o(win_tl), .win_tc_o(win_tc), .win_tr_o(win_tr),
		.win_ml_o(win_ml), .win_mc_o(win_mc), .win_mr_o(win_mr),
		.win_bl_o(win_bl), .win_bc_o(win_bc), .win_br_o(win_br),
		.win_site_o(win_site), .win_emit_o(win_emit)
	);

	bilinear_interp #(.PIXEL_WIDTH(PIXEL_WIDTH)) u_bilinear_interp
	(
		.clk_i(clk_i), .line_valid_i(line_valid_i),
		.win_valid_i(win_valid),
		.win_tl_i(win_tl), .win_tc_i(win_tc), .win_tr_i(win_tr),
		.win_ml_i(win_ml), .win_mc_i(win_mc), .win_mr_i(win_mr),
		.win_bl_i(win_bl), .win_bc_i(win_bc), .win_br_i(win_br),
		.win_site_i(win_site), .win_emit_i(win_emit),
		.pipe_advance_o(pipe_advance),
		.rgb_valid_o(rgb_valid_o), .rgb_ready_i(rgb_ready_i),
		.rgb_red_o(rgb_red_o), .rgb_green_o(rgb_green_o), .rgb_blue_o(rgb_blue_o)
	);

endmodule

`default_nettype wire

// ==== include/debayer_ref_model.svh ====
`ifndef DEBAYER_REF_MODEL_SVH
`define DEBAYER_REF_MODEL_SVH

typedef enum int {FILL_FLAT, FILL_RAMP, FILL_RANDOM} fill_mode_e;

// raw BGGR frame with one entry per pixel in raster order
task automatic build_image(input int height, input int width, input fill_mode_e mode,
	input int unsigned flat_value, input int pix_width, output int unsigned img[]);
	int unsigned mask;
	mask = (32'd1 << pix_width) - 1;
	img = new[height * width];
	for (int r = 0; r < height; r++)
	begin
		for (int c = 0; c < width; c++)
		begin
			case (mode)
				FILL_FLAT:   img[r * width + c] = flat_value & mask;
				FILL_RAMP:   img[r * width + c] = ((r * width + c) * 11) & mask;
				default:     img[r * width + c] = $urandom & mask;
			endcase
		end
	end
endtask

function automatic int interior_count(input int height, input int width);
	if (height < 3 || width < 3)
		return 0;
	return (height - 2) * (width - 2);
endfunction

// bilinear rule for every interior centre in raster order
task automatic predict_frame(input int unsigned img[], input int height, input int width,
	ref int unsigned red_q[$], ref int unsigned green_q[$], ref int unsigned blue_q[$]);
	int unsigned ctr;
	int unsigned orth;
	int unsigned diag;
	int unsigned horz;
	int unsigned vert;
	for (int r = 1; r < height - 1; r++)
	begin
		for (int c = 1; c < width - 1; c++)
		begin
			ctr  = img[r * width + c];
			horz = (img[r * width + c - 1] + img[r * width + c + 1]) >> 1;
			vert = (img[(r - 1) * width + c] + img[(r + 1) * width + c]) >> 1;
			orth = (img[(r - 1) * width + c] + img[(r + 1) * width + c]
				+ img[r * width + c - 1] + img[r * width + c + 1]) >> 2;
			diag = (img[(r - 1) * width + c - 1] + img[(r - 1) * width + c + 1]
				+ img[(r + 1) * width + c - 1] + img[(r + 1) * width + c + 1]) >> 2;
			case ({r[0], c[0]})
				2'b00:	// blue site
				begin
					red_q.push_back(diag);
					green_q.push_back(orth);
					blue_q.push_back(ctr);
				end
				2'b01:	// green on a blue row
				begin
					red_q.push_back(vert);
					green_q.push_back(ctr);
					blue_q.push_back(horz);
				end
				2'b10:	// green on a red row
				begin
					red_q.push_back(horz);
					green_q.push_back(ctr);
					blue_q.push_back(vert);
				end
				default:	// red site
				begin
					red_q.push_back(ctr);
					green_q.push_back(orth);
					blue_q.push_back(diag);
				end
			endcase
		end
	end
endtask

`endif

// ==== bench/tb_debayer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_debayer;

	localparam int IMG_W          = 8;
	localparam int PIX_W          = 10;
	localparam int SEED           = 32'head5_50e4;
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int IDLE_CYCLES    = 12;	// quiet beats between frames
	localparam int NUM_CASES      = 7;

	`include "debayer_ref_model.svh"

	// height, fill mode, flat value, input gap %, output stall %, expected results
	int         case_height [NUM_CASES] = '{6, 6, 7, 6, 2, 5, 4};
	fill_mode_e case_mode   [NUM_CASES] = '{FILL_FLAT, FILL_RAMP, FILL_RANDOM, FILL_RANDOM,
		FILL_FLAT, FILL_RAMP, FILL_RANDOM};
	int         case_flat   [NUM_CASES] = '{512, 0, 0, 0, 1023, 0, 0};
	int         case_gap    [NUM_CASES] = '{0, 0, 0, 30, 0, 20, 50};
	int         case_stall  [NUM_CASES] = '{0, 0, 0, 40, 0, 20, 50};
	int         case_count  [NUM_CASES] = '{24, 24, 30, 24, 0, 18, 12};

	logic             clk_i;
	logic             line_valid_i;
	logic             pix_valid_i;
	logic             pix_ready_o;
	logic [PIX_W-1:0] pix_data_i;
	logic             pix_sof_i;
	logic             rgb_valid_o;
	logic             rgb_ready_i;
	logic [PIX_W-1:0] rgb_red_o;
	logic [PIX_W-1:0] rgb_green_o;
	logic [PIX_W-1:0] rgb_blue_o;

	int unsigned red_q[$];	// expected results in raster order
	int unsigned green_q[$];
	int unsigned blue_q[$];
	int          mismatch_count = 0;
	int          failure_count  = 0;
	int          received       = 0;
	int          stall_pct      = 0;
	int unsigned cur_flat       = 0;
	fill_mode_e  cur_mode       = FILL_RAMP;
	bit          timed_out      = 1'b0;

	debayer_top #(.PIXEL_WIDTH(PIX_W), .IMG_WIDTH(IMG_W)) DUT
	(
		.clk_i(clk_i), .line_valid_i(line_valid_i),
		.pix_valid_i(pix_valid_i), .pix_ready_o(pix_ready_o),
		.pix_data_i(pix_data_i), .pix_sof_i(pix_sof_i),
		.rgb_valid_o(rgb_valid_o), .rgb_ready_i(rgb_ready_i),
		.rgb_red_o(rgb_red_o), .rgb_green_o(rgb_green_o), .rgb_blue_o(rgb_blue_o)
	);

	initial
	begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	task automatic check_value(input string what, input int unsigned actual,
		input int unsigned expected);
		if (actual !== expected)
		begin
			mismatch_count++;
			$display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
		end
	endtask

	// random back-pressure on the output side
	always @(posedge clk_i)
		rgb_ready_i <= (($urandom % 100) >= stall_pct);

	// outputs are sampled mid-cycle and transfer on the next rising edge
	always @(negedge clk_i)
	begin
		if (!line_valid_i && rgb_valid_o && rgb_ready_i)
		begin
			received++;
			if (red_q.size() == 0)
			begin
				failure_count++;
				$display("an RGB result came out that no pixel of the frame accounts for");
			end
			else
			begin
				check_value("red", 32'(rgb_red_o), red_q.pop_front());
				check_value("green", 32'(rgb_green_o), green_q.pop_front());
				check_value("blue", 32'(rgb_blue_o), blue_q.pop_front());
			end
			if (cur_mode == FILL_FLAT)
			begin
				check_value("flat red", 32'(rgb_red_o), cur_flat);
				check_value("flat green", 32'(rgb_green_o), cur_flat);
				check_value("flat blue", 32'(rgb_blue_o), cur_flat);
			end
		end
	end

	task automatic send_frame(input int unsigned img[], input int gap);
		int idx;
		int stalled;
		idx = 0;
		while (idx < img.size() && !timed_out)
		begin
			@(posedge clk_i);
			if (($urandom % 100) < gap)
			begin
				pix_valid_i <= 1'b0;	// bubble
				pix_sof_i   <= 1'b0;
			end
			else
			begin
				pix_valid_i <= 1'b1;
				pix_data_i  <= PIX_W'(img[idx]);
				pix_sof_i   <= (idx == 0);
			end
			@(negedge clk_i);
			stalled = 0;
			while (pix_valid_i && !pix_ready_o && !timed_out)	// hold the beat
			begin
				@(negedge clk_i);
				stalled++;
				if (stalled > TIMEOUT_CYCLES)
				begin
					$display("timeout: pix_ready_o stayed low at pixel %0d", idx);
					failure_count++;
					timed_out = 1'b1;
				end
			end
			if (pix_valid_i)
				idx++;
		end
		@(posedge clk_i);
		pix_valid_i <= 1'b0;
		pix_sof_i   <= 1'b0;
	endtask

	task automatic run_case(input int k);
		int unsigned img[];
		int          waited;
		stall_pct = case_stall[k];
		cur_mode  = case_mode[k];
		cur_flat  = case_flat[k];
		received  = 0;
		build_image(case_height[k], IMG_W, case_mode[k], case_flat[k], PIX_W, img);
		predict_frame(img, case_height[k], IMG_W, red_q, green_q, blue_q);
		check_value("model result count", interior_count(case_height[k], IMG_W),
			case_count[k]);
		send_frame(img, case_gap[k]);
		waited = 0;
		while (received < case_count[k] && !timed_out)
		begin
			@(posedge clk_i);
			waited++;
			if (waited > TIMEOUT_CYCLES)
			begin
				$display("timeout: case %0d gave %0d of %0d results", k, received, case_count[k]);
				failure_count++;
				timed_out = 1'b1;
			end
		end
		repeat (IDLE_CYCLES) @(posedge clk_i);	// extra or late results would show here
		check_value("result count", received, case_count[k]);
		red_q.delete();
		green_q.delete();
		blue_q.delete();
	endtask

	initial
	begin
		void'($urandom(SEED));
		line_valid_i = 1'b1;
		pix_valid_i  = 1'b0;
		pix_data_i   = '0;
		pix_sof_i    = 1'b0;
		rgb_ready_i  = 1'b1;
		repeat (2) @(posedge clk_i);
		line_valid_i <= 1'b0;
		@(negedge clk_i);
		check_value("rgb_valid_o after reset", 32'(rgb_valid_o), 0);
		check_value("pix_ready_o after reset", 32'(pix_ready_o), 1);
		for (int k = 0; k < NUM_CASES && !timed_out; k++)
			run_case(k);
		$display("Errors: %0d value mismatches, %0d other failures",
			mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
hw/debayer_pkg.sv
hw/line_ram.sv
hw/column_fetch.sv
hw/window_3x3.sv
hw/bilinear_interp.sv
hw/debayer_top.sv
bench/tb_debayer.sv

// ==== Makefile ====
SIM       := verilator
SIMFLAGS  := --binary --timing
TOP       := tb_debayer
FILELIST  := sources.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
